// ==== muldiv_unit.f ====
+incdir+design
design/muldiv_pkg.sv
design/muldiv_issue.sv
design/multiplier.sv
design/divider.sv
design/muldiv_unit.sv
tests/muldiv_unit_tb.sv

// ==== tests/muldiv_unit_tb.sv ====
/*
 * Testbench for the RV32M multiply/divide cluster.
 * Random and directed operations, random back-pressure on rsp_ready_i.
 * Concurrent assertions compare against a reference model and check
 * latency and the valid/ready protocol. One operation at a time.
 */
`include "muldiv_config.svh"

module muldiv_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import muldiv_pkg::*;

    localparam int N_RAND  = 200;
    localparam int N_OPS   = 2 * N_RAND + 64 + 8;  // Random, mul corners, div corners
    localparam int WD_TIME = N_OPS * 40 * 20 + 1000;

    logic   clk_i;
    logic   reset_i;
    logic   cmd_valid_i;
    logic   cmd_ready_o;
    md_op_t cmd_op_i;
    word_t  cmd_src1_i;
    word_t  cmd_src2_i;
    logic   rsp_valid_o;
    logic   rsp_ready_i;
    word_t  rsp_rslt_o;

    logic [31:0] lfsr_q = 32'h7eb;
    int          errors = 0;
    int          n_ops = 0;
    string       cur_name = "none";
    string       exp_name_q = "none";
    word_t       exp_rslt_q;
    int          exp_lat_q;
    int          since_q;                // Cycles since acceptance
    logic        in_flight_q;

    muldiv_unit uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_op_i    (cmd_op_i),
        .cmd_src1_i  (cmd_src1_i),
        .cmd_src2_i  (cmd_src2_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rslt_o  (rsp_rslt_o)
    );

    always #10 clk_i = ~clk_i;

    // --------------------------------------------------
    // Galois LFSR, one step per bit
    function automatic logic rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], rand_bit()};
        return v;
    endfunction

    // RV32M result from the ISA rules
    function automatic word_t model_result(input md_op_t op, input word_t a, input word_t b);
        logic [63:0]        prod;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            MD_MUL:    prod = {32'b0, a} * {32'b0, b};
            MD_MULH:   prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            MD_MULHSU: prod = {{32{a[31]}}, a} * {32'b0, b};
            default:   prod = {32'b0, a} * {32'b0, b};
        endcase
        case (op)
            MD_MUL:  return prod[31:0];
            MD_DIV:  return (b == '0) ? '1 : ovf ? a : word_t'(sa / sb);
            MD_DIVU: return (b == '0) ? '1 : a / b;
            MD_REM:  return (b == '0) ? a : ovf ? '0 : word_t'(sa % sb);
            MD_REMU: return (b == '0) ? a : a % b;
            default: return prod[63:32];  // High word variants
        endcase
    endfunction

    // --------------------------------------------------
    // Expected value and latency, captured at acceptance
    always @(posedge clk_i) begin
        if (reset_i) begin
            in_flight_q <= 1'b0;
            since_q     <= 0;
        end else if (cmd_valid_i && cmd_ready_o) begin
            in_flight_q <= 1'b1;
            since_q     <= 1;
            exp_rslt_q  <= model_result(cmd_op_i, cmd_src1_i, cmd_src2_i);
            exp_lat_q   <= (cmd_op_i[2] && cmd_src2_i != '0) ? `MD_DIV_STEPS + 2 : 2;
            exp_name_q  <= cur_name;
            n_ops       <= n_ops + 1;
        end else if (in_flight_q) begin
            if (rsp_valid_o && rsp_ready_i) in_flight_q <= 1'b0;
            if (!rsp_valid_o) since_q <= since_q + 1;
        end
    end

    // --------------------------------------------------
    // Checks
    a_reset_idle: assert property (@(posedge clk_i) reset_i |=> cmd_ready_o && !rsp_valid_o)
        else begin
            errors++;
            $display("after reset the unit is not idle with cmd_ready_o high");
        end

    a_result: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o |-> rsp_rslt_o == exp_rslt_q)
        else begin
            errors++;
            $display("error %s expected %h actual %h", exp_name_q,
                     $sampled(exp_rslt_q), $sampled(rsp_rslt_o));
        end

    a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(rsp_valid_o) |-> since_q == exp_lat_q)
        else begin
            errors++;
            $display("error %s latency expected %0d actual %0d", exp_name_q,
                     $sampled(exp_lat_q), $sampled(since_q));
        end

    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rslt_o))
        else begin
            errors++;
            $display("response dropped or changed while rsp_ready_i was low");
        end

    a_no_accept: assert property (@(posedge clk_i) disable iff (reset_i)
        in_flight_q |-> !cmd_ready_o)
        else begin
            errors++;
            $display("cmd_ready_o high while an operation is in flight");
        end

    a_one_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o |-> in_flight_q)
        else begin
            errors++;
            $display("response valid without an accepted command");
        end

    a_ready_back: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_o && rsp_ready_i |=> cmd_ready_o)
        else begin
            errors++;
            $display("cmd_ready_o not high on the cycle after the response");
        end

    // --------------------------------------------------
    // One operation through accept and response, with random stalls
    task automatic run_op(input md_op_t op, input word_t a, input word_t b, input string name);
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= op;
        cmd_src1_i  <= a;
        cmd_src2_i  <= b;
        cur_name    <= name;
        do begin
            @(posedge clk_i);
        end while (!cmd_ready_o);
        do begin
            cmd_valid_i <= rand_bit();             // Must be ignored in flight
            rsp_ready_i <= (rand_bits(2) != '0);   // About one stall in four
            @(posedge clk_i);
        end while (!(rsp_valid_o && rsp_ready_i));
    endtask

    initial begin : stimulus
        word_t corners [4];
        word_t r;
        word_t a;
        word_t b;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_op_i    = MD_MUL;
        cmd_src1_i  = '0;
        cmd_src2_i  = '0;
        rsp_ready_i = 1'b1;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;

        for (int i = 0; i < N_RAND; i++) begin
            r = rand_bits(2);
            a = rand_bits(32);
            b = rand_bits(32);
            run_op(md_op_t'({1'b0, r[1:0]}), a, b, "mul_rand");
        end
        for (int op = 0; op < 4; op++) begin
            for (int j = 0; j < 4; j++) begin
                for (int k = 0; k < 4; k++) begin
                    run_op(md_op_t'(op[2:0]), corners[j], corners[k], "mul_corner");
                end
            end
        end
        for (int i = 0; i < N_RAND; i++) begin
            r = rand_bits(2);
            a = rand_bits(32);
            b = rand_bits(1) ? rand_bits(32) : rand_bits(8);  // Mix of small divisors
            if (b == '0) b = 32'd1;
            run_op(md_op_t'({1'b1, r[1:0]}), a, b, "div_rand");
        end
        for (int op = 4; op < 8; op++) begin
            run_op(md_op_t'(op[2:0]), rand_bits(32), '0, "div_zero");
            run_op(md_op_t'(op[2:0]), 32'h8000_0000, 32'hffff_ffff, "div_ovf");
        end

        cmd_valid_i <= 1'b0;
        rsp_ready_i <= 1'b1;
        repeat (3) @(posedge clk_i);
        if (n_ops != N_OPS) begin
            errors++;
            $display("only %0d of %0d operations were accepted", n_ops, N_OPS);
        end
        $display("Operations: %0d  errors: %0d", n_ops, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WD_TIME);
        $display("Timeout waiting for the unit, %0d operations accepted", n_ops);
        $display("Operations: %0d  errors: %0d", n_ops, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== design/muldiv_unit.sv ====
/*
 * RV32M multiply/divide cluster.
 * Valid/ready command and response channels, one operation at a time.
 * Multiply answers in 2 cycles, divide in 34 (2 for a zero divisor).
 */
module muldiv_unit (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               cmd_valid_i,
    output logic               cmd_ready_o,
    input  muldiv_pkg::md_op_t cmd_op_i,
    input  muldiv_pkg::word_t  cmd_src1_i,
    input  muldiv_pkg::word_t  cmd_src2_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output muldiv_pkg::word_t  rsp_rslt_o
);
    import muldiv_pkg::*;

    logic   mul_start;
    logic   div_start;
    md_op_t op;
    word_t  src1;
    word_t  src2;
    logic   unit_ready;
    logic   mul_done;
    word_t  mul_rslt;
    logic   div_done;
    word_t  div_rslt;

    muldiv_issue issue (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_op_i     (cmd_op_i),
        .cmd_src1_i   (cmd_src1_i),
        .cmd_src2_i   (cmd_src2_i),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_rslt_o   (rsp_rslt_o),
        .mul_start_o  (mul_start),
        .div_start_o  (div_start),
        .op_o         (op),
        .src1_o       (src1),
        .src2_o       (src2),
        .unit_ready_o (unit_ready),
        .mul_done_i   (mul_done),
        .mul_rslt_i   (mul_rslt),
        .div_done_i   (div_done),
        .div_rslt_i   (div_rslt)
    );

    multiplier mul (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .start_i     (mul_start),
        .op_i        (op),
        .src1_i      (src1),
        .src2_i      (src2),
        .rsp_ready_i (unit_ready),
        .done_o      (mul_done),
        .rslt_o      (mul_rslt)
    );

    divider div (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .start_i     (div_start),
        .op_i        (op),
        .src1_i      (src1),
        .src2_i      (src2),
        .rsp_ready_i (unit_ready),
        .done_o      (div_done),
        .rslt_o      (div_rslt)
    );

endmodule

// ==== design/divider.sv ====
/*
 * Sequential restoring divider for DIV, DIVU, REM and REMU.
 * Latency is one check cycle plus MD_DIV_STEPS iterations.
 * Divide by zero skips the iterations: quotient is all ones and
 * remainder is the dividend. Signed overflow gives the most negative
 * value with remainder zero, as RV32M requires.
 */
`include "muldiv_config.svh"

module divider (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               start_i,
    input  muldiv_pkg::md_op_t op_i,
    input  muldiv_pkg::word_t  src1_i,
    input  muldiv_pkg::word_t  src2_i,
    input  logic               rsp_ready_i,
    output logic               done_o,
    output muldiv_pkg::word_t  rslt_o
);
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(`MD_DIV_STEPS);

    typedef enum logic [1:0] {ST_IDLE, ST_CHECK, ST_EXEC, ST_RET} div_state_t;

    div_state_t       state_q;
    logic [CNT_W-1:0] cntr_q;
    word_t            rem_q;      // Holds the raw dividend until check
    word_t            quot_q;
    word_t            divisor_q;
    logic             dividend_neg_q;
    logic             divisor_neg_q;
    logic             quot_neg_q;
    logic             rem_neg_q;
    logic             is_rem_q;
    logic             is_signed;
    word_t            dividend_mag;
    word_t            divisor_mag;
    logic [`MD_XLEN:0] diff;      // Top bit is the borrow

    assign is_signed    = (op_i == MD_DIV) || (op_i == MD_REM);
    assign dividend_mag = dividend_neg_q ? -rem_q : rem_q;
    assign divisor_mag  = divisor_neg_q ? -divisor_q : divisor_q;
    assign diff         = {rem_q, quot_q[`MD_XLEN-1]} - {1'b0, divisor_q};

    // --------------------------------------------------
    // Control
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cntr_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (start_i) state_q <= ST_CHECK;
                ST_CHECK: begin
                    cntr_q  <= CNT_W'(`MD_DIV_STEPS - 1);
                    state_q <= (divisor_q == '0) ? ST_RET : ST_EXEC;
                end
                ST_EXEC: begin
                    cntr_q <= cntr_q - 1'b1;
                    if (cntr_q == '0) state_q <= ST_RET;
                end
                ST_RET: if (rsp_ready_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Datapath
    always_ff @(posedge clk_i) begin
        case (state_q)
            ST_IDLE: if (start_i) begin
                is_rem_q       <= (op_i == MD_REM) || (op_i == MD_REMU);
                dividend_neg_q <= is_signed && src1_i[`MD_XLEN-1];
                divisor_neg_q  <= is_signed && src2_i[`MD_XLEN-1];
                quot_neg_q     <= is_signed && (src1_i[`MD_XLEN-1] ^ src2_i[`MD_XLEN-1]);
                rem_neg_q      <= is_signed && src1_i[`MD_XLEN-1];
                rem_q          <= src1_i;
                divisor_q      <= src2_i;
            end
            ST_CHECK: begin
                if (divisor_q == '0) begin
                    quot_q     <= '1;  // Remainder keeps the dividend
                    quot_neg_q <= 1'b0;
                    rem_neg_q  <= 1'b0;
                end else begin
                    divisor_q <= divisor_mag;
                    rem_q     <= '0;
                    quot_q    <= dividend_mag;
                end
            end
            ST_EXEC: begin
                if (!diff[`MD_XLEN]) begin
                    {rem_q, quot_q} <= {diff[`MD_XLEN-1:0], quot_q[`MD_XLEN-2:0], 1'b1};
                end else begin
                    {rem_q, quot_q} <= {rem_q[`MD_XLEN-2:0], quot_q, 1'b0};  // Restore
                end
            end
            default: ;
        endcase
    end

    assign done_o = (state_q == ST_RET);
    assign rslt_o = !done_o  ? '0 :
                    is_rem_q ? (rem_neg_q ? -rem_q : rem_q) :
                               (quot_neg_q ? -quot_q : quot_q);

    // Exactly one iteration per quotient bit, then return
    a_cntr: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(state_q == ST_EXEC)
            |-> ##(`MD_DIV_STEPS - 1) state_q == ST_EXEC ##1 state_q == ST_RET);

    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        done_o && !rsp_ready_i |=> done_o && $stable(rslt_o));

endmodule

// ==== design/multiplier.sv ====
/*
 * Two-cycle RV32M multiplier.
 * Start captures sign-extended operands, the next cycle forms the
 * full product. The result is held until unit_ready is seen in the
 * return state and reads as zero otherwise.
 */
`include "muldiv_config.svh"

module multiplier (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               start_i,
    input  muldiv_pkg::md_op_t op_i,
    input  muldiv_pkg::word_t  src1_i,
    input  muldiv_pkg::word_t  src2_i,
    input  logic               rsp_ready_i,
    output logic               done_o,
    output muldiv_pkg::word_t  rslt_o
);
    import muldiv_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_RET} mul_state_t;

    mul_state_t                  state_q;
    logic signed [`MD_XLEN:0]    mcand_q;  // 33 bits, sign or zero extended
    logic signed [`MD_XLEN:0]    mplier_q;
    logic        [2*`MD_XLEN-1:0] product_q;
    logic                        is_high_q;
    logic                        src1_signed;
    logic                        src2_signed;

    assign src1_signed = (op_i == MD_MULH) || (op_i == MD_MULHSU);
    assign src2_signed = (op_i == MD_MULH);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (start_i) state_q <= ST_EXEC;
                ST_EXEC: state_q <= ST_RET;
                ST_RET:  if (rsp_ready_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start_i) begin
            mcand_q   <= {src1_signed && src1_i[`MD_XLEN-1], src1_i};
            mplier_q  <= {src2_signed && src2_i[`MD_XLEN-1], src2_i};
            is_high_q <= (op_i != MD_MUL);
        end
        if (state_q == ST_EXEC) product_q <= mcand_q * mplier_q;  // Low 64 bits suffice
    end

    assign done_o = (state_q == ST_RET);
    assign rslt_o = !done_o   ? '0 :
                    is_high_q ? product_q[2*`MD_XLEN-1:`MD_XLEN] : product_q[`MD_XLEN-1:0];

    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        done_o && !rsp_ready_i |=> done_o && $stable(rslt_o));

endmodule

// ==== design/muldiv_issue.sv ====
/*
 * Command acceptance and response return for the multiply/divide cluster.
 * Only one operation is in flight. cmd_ready_o drops for the whole
 * operation and returns the cycle after the response handshake.
 * Unit done and result pass through without a register stage.
 */
`include "muldiv_config.svh"

module muldiv_issue (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               cmd_valid_i,
    output logic               cmd_ready_o,
    input  muldiv_pkg::md_op_t cmd_op_i,
    input  muldiv_pkg::word_t  cmd_src1_i,
    input  muldiv_pkg::word_t  cmd_src2_i,
    input  logic               rsp_ready_i,
    output logic               rsp_valid_o,
    output muldiv_pkg::word_t  rsp_rslt_o,
    output logic               mul_start_o,
    output logic               div_start_o,
    output muldiv_pkg::md_op_t op_o,
    output muldiv_pkg::word_t  src1_o,
    output muldiv_pkg::word_t  src2_o,
    output logic               unit_ready_o,
    input  logic               mul_done_i,
    input  muldiv_pkg::word_t  mul_rslt_i,
    input  logic               div_done_i,
    input  muldiv_pkg::word_t  div_rslt_i
);
    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_MUL, ST_WAIT_DIV} issue_state_t;

    issue_state_t state_q;
    logic         accept;
    logic         is_div;
    logic         rsp_fire;

    // --------------------------------------------------
    // Command side
    assign cmd_ready_o = (state_q == ST_IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;
    assign is_div      = cmd_op_i[`MD_FUNCT3_W-1];  // Family bit only

    assign mul_start_o = accept && !is_div;
    assign div_start_o = accept && is_div;
    assign op_o        = cmd_op_i;
    assign src1_o      = cmd_src1_i;
    assign src2_o      = cmd_src2_i;

    // --------------------------------------------------
    // Response side, from the unit that owns the operation
    always_comb begin
        rsp_valid_o = 1'b0;
        rsp_rslt_o  = '0;
        case (state_q)
            ST_WAIT_MUL: begin
                rsp_valid_o = mul_done_i;
                rsp_rslt_o  = mul_rslt_i;
            end
            ST_WAIT_DIV: begin
                rsp_valid_o = div_done_i;
                rsp_rslt_o  = div_rslt_i;
            end
            default: ;
        endcase
    end

    assign rsp_fire     = rsp_valid_o && rsp_ready_i;
    assign unit_ready_o = rsp_ready_i && (state_q != ST_IDLE);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:     if (accept) state_q <= is_div ? ST_WAIT_DIV : ST_WAIT_MUL;
                ST_WAIT_MUL,
                ST_WAIT_DIV: if (rsp_fire) state_q <= ST_IDLE;
                default:     state_q <= ST_IDLE;
            endcase
        end
    end

    // New work only starts with both units back in idle
    a_start_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        (mul_start_o || div_start_o) |-> !mul_done_i && !div_done_i);

    // Done comes only from the unit that owns the operation
    a_done_owner: assert property (@(posedge clk_i) disable iff (reset_i)
        (!mul_done_i || state_q == ST_WAIT_MUL) && (!div_done_i || state_q == ST_WAIT_DIV));

endmodule

// ==== design/muldiv_pkg.sv ====
/*
 * Types shared by the multiply/divide RTL.
 * Operation codes follow RV32M funct3 directly. The top bit of the
 * code selects the divide family.
 */
`include "muldiv_config.svh"

package muldiv_pkg;

    // Operand and result word
    typedef logic [`MD_XLEN-1:0] word_t;

    // RV32M funct3 encodings
    typedef enum logic [`MD_FUNCT3_W-1:0] {
        MD_MUL    = 3'd0,
        MD_MULH   = 3'd1,
        MD_MULHSU = 3'd2,
        MD_MULHU  = 3'd3,
        MD_DIV    = 3'd4,
        MD_DIVU   = 3'd5,
        MD_REM    = 3'd6,
        MD_REMU   = 3'd7
    } md_op_t;

endpackage

// ==== design/muldiv_config.svh ====
/*
 * Width and timing constants for the RV32M multiply/divide cluster.
 * MD_DIV_STEPS must equal MD_XLEN for the restoring divider
 * to produce a complete quotient.
 */
`ifndef MULDIV_CONFIG_SVH
`define MULDIV_CONFIG_SVH

// Operand and result width
`define MD_XLEN 32

// RV32M funct3 field
`define MD_FUNCT3_W 3

// One quotient bit per divider iteration
`define MD_DIV_STEPS `MD_XLEN

`endif
